// ==== rtl/misc_alu_consts.svh ====
`ifndef MISC_ALU_CONSTS_SVH
`define MISC_ALU_CONSTS_SVH

`define MISC_DATA_WIDTH 16 // operands are signed; the accumulator is twice this.
`define MISC_SHIFT_WIDTH 4
`define MISC_DEST_WIDTH 4
`define MISC_OP_WIDTH 4

`define MISC_OP_LSH 4'd0
`define MISC_OP_RSH 4'd1 // logical, then sign-extended into the result.
`define MISC_OP_ABS 4'd2
`define MISC_OP_MIN 4'd3
`define MISC_OP_MAX 4'd4
`define MISC_OP_CLAMP 4'd5
`define MISC_OP_MOV_ACC 4'd6 // arithmetic shift of the accumulator.
`define MISC_OP_MOV_UACC 4'd7
`define MISC_OP_MOV_LACC 4'd8

`endif

// ==== rtl/misc_alu_pkg.sv ====
`include "misc_alu_consts.svh"

package misc_alu_pkg;
	typedef logic signed [`MISC_DATA_WIDTH-1:0] word_t;
	typedef logic signed [2*`MISC_DATA_WIDTH-1:0] acc_t;
	typedef logic [`MISC_SHIFT_WIDTH-1:0] shift_t;
	typedef logic [`MISC_DEST_WIDTH-1:0] dest_t;
	typedef logic [`MISC_OP_WIDTH-1:0] misc_op_t;

	typedef struct packed {
		misc_op_t op;
		word_t arg_a;
		word_t arg_b;
		word_t arg_c;
		acc_t accumulator;
		shift_t shift;
		logic saturate_disable;
		dest_t dest;
	} misc_req_t;

	typedef struct packed {
		misc_op_t op;
		logic [1:0] shift; // only the fine shift bits are left to apply.
		logic saturate_disable;
		dest_t dest;
		acc_t acc_shift;
		word_t upper_acc;
		word_t lower_acc;
		word_t abs_val;
		word_t min_val;
		word_t max_val;
		word_t lsh_val;
		word_t rsh_val;
		word_t clamp_lo;
		word_t clamp_hi;
		word_t clamp_val; // still the raw value of a here.
	} prep_t;

	typedef struct packed {
		misc_op_t op;
		logic [1:0] shift;
		logic saturate_disable;
		dest_t dest;
		acc_t acc_shift;
		word_t upper_acc;
		word_t lower_acc;
		word_t abs_val;
		word_t min_val;
		word_t max_val;
		word_t lsh_val;
		word_t rsh_val;
		word_t clamp_val;
	} finish_t;

	typedef struct packed {
		acc_t result;
		dest_t dest;
	} misc_resp_t;
endpackage

// ==== rtl/misc_alu_prep.sv ====
`timescale 1ns/1ps

`include "misc_alu_consts.svh"

module misc_alu_prep
	import misc_alu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input misc_req_t req,
	output logic out_valid,
	input logic out_ready,
	output prep_t stage
);

	acc_t acc_by8;
	acc_t acc_by4;
	word_t lsh_by8;
	word_t lsh_by4;
	word_t rsh_by8;
	word_t rsh_by4;
	logic clamp_swap;
	prep_t prep_next;

	assign in_ready = ~out_valid | out_ready;

	always_comb begin
		acc_by8 = req.shift[3] ? (req.accumulator >>> 8) : req.accumulator;
		acc_by4 = req.shift[2] ? (acc_by8 >>> 4) : acc_by8;
		lsh_by8 = req.shift[3] ? (req.arg_a << 8) : req.arg_a;
		lsh_by4 = req.shift[2] ? (lsh_by8 << 4) : lsh_by8;
		rsh_by8 = req.shift[3] ? (req.arg_a >> 8) : req.arg_a; // zeros shift in from the top.
		rsh_by4 = req.shift[2] ? (rsh_by8 >> 4) : rsh_by8;
	end

	assign clamp_swap = req.arg_c < req.arg_b;

	always_comb begin
		prep_next.op = req.op;
		prep_next.shift = req.shift[1:0];
		prep_next.saturate_disable = req.saturate_disable;
		prep_next.dest = req.dest;
		prep_next.acc_shift = acc_by4;
		prep_next.upper_acc = req.accumulator[2*`MISC_DATA_WIDTH-1:`MISC_DATA_WIDTH];
		prep_next.lower_acc = req.accumulator[`MISC_DATA_WIDTH-1:0];
		prep_next.abs_val = (req.arg_a < 0) ? -req.arg_a : req.arg_a; // -32768 wraps to itself.
		prep_next.min_val = (req.arg_a < req.arg_b) ? req.arg_a : req.arg_b;
		prep_next.max_val = (req.arg_a > req.arg_b) ? req.arg_a : req.arg_b;
		prep_next.lsh_val = lsh_by4;
		prep_next.rsh_val = rsh_by4;
		prep_next.clamp_lo = clamp_swap ? req.arg_c : req.arg_b;
		prep_next.clamp_hi = clamp_swap ? req.arg_b : req.arg_c;
		prep_next.clamp_val = req.arg_a;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			stage <= '0;
		end else if (in_valid && in_ready) begin
			out_valid <= 1'b1;
			stage <= prep_next;
		end else if (out_ready) begin
			out_valid <= 1'b0; // drained, or it was already empty.
		end
	end

endmodule

// ==== rtl/misc_alu_finish.sv ====
`timescale 1ns/1ps

`include "misc_alu_consts.svh"

module misc_alu_finish
	import misc_alu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input prep_t stage_in,
	output logic out_valid,
	input logic out_ready,
	output finish_t stage_out
);

	acc_t acc_by2;
	word_t lsh_by2;
	word_t rsh_by2;
	finish_t finish_next;

	assign in_ready = ~out_valid | out_ready;

	always_comb begin
		acc_by2 = stage_in.shift[1] ? (stage_in.acc_shift >>> 2) : stage_in.acc_shift;
		lsh_by2 = stage_in.shift[1] ? (stage_in.lsh_val << 2) : stage_in.lsh_val;
		rsh_by2 = stage_in.shift[1] ? (stage_in.rsh_val >> 2) : stage_in.rsh_val;
	end

	always_comb begin
		finish_next.op = stage_in.op;
		finish_next.shift = stage_in.shift;
		finish_next.saturate_disable = stage_in.saturate_disable;
		finish_next.dest = stage_in.dest;
		finish_next.acc_shift = stage_in.shift[0] ? (acc_by2 >>> 1) : acc_by2;
		finish_next.upper_acc = stage_in.upper_acc;
		finish_next.lower_acc = stage_in.lower_acc;
		finish_next.abs_val = stage_in.abs_val;
		finish_next.min_val = stage_in.min_val;
		finish_next.max_val = stage_in.max_val;
		finish_next.lsh_val = stage_in.shift[0] ? (lsh_by2 << 1) : lsh_by2;
		finish_next.rsh_val = stage_in.shift[0] ? (rsh_by2 >> 1) : rsh_by2;
		if (stage_in.clamp_val < stage_in.clamp_lo) begin
			finish_next.clamp_val = stage_in.clamp_lo;
		end else if (stage_in.clamp_val > stage_in.clamp_hi) begin
			finish_next.clamp_val = stage_in.clamp_hi;
		end else begin
			finish_next.clamp_val = stage_in.clamp_val; // bounds were ordered in the first stage.
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			stage_out <= '0;
		end else if (in_valid && in_ready) begin
			out_valid <= 1'b1;
			stage_out <= finish_next;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

endmodule

// ==== rtl/misc_alu_select.sv ====
`timescale 1ns/1ps

`include "misc_alu_consts.svh"

module misc_alu_select
	import misc_alu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input finish_t stage_in,
	output logic out_valid,
	input logic out_ready,
	output misc_resp_t resp
);

	localparam acc_t SAT_MAX = 32'sd32767;
	localparam acc_t SAT_MIN = -32'sd32768;

	acc_t value;
	acc_t value_sat;

	assign in_ready = ~out_valid | out_ready;

	// word_t fields are signed, so assigning them to value extends the sign.
	always_comb begin
		case (stage_in.op)
			`MISC_OP_LSH: value = stage_in.lsh_val;
			`MISC_OP_RSH: value = stage_in.rsh_val;
			`MISC_OP_ABS: value = stage_in.abs_val;
			`MISC_OP_MIN: value = stage_in.min_val;
			`MISC_OP_MAX: value = stage_in.max_val;
			`MISC_OP_CLAMP: value = stage_in.clamp_val;
			`MISC_OP_MOV_ACC: value = stage_in.acc_shift;
			`MISC_OP_MOV_UACC: value = stage_in.upper_acc;
			`MISC_OP_MOV_LACC: value = stage_in.lower_acc;
			default: value = '0;
		endcase
	end

	assign value_sat = (value < SAT_MIN) ? SAT_MIN : ((value > SAT_MAX) ? SAT_MAX : value);

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
			resp <= '0;
		end else if (in_valid && in_ready) begin
			out_valid <= 1'b1;
			resp.result <= stage_in.saturate_disable ? value : value_sat;
			resp.dest <= stage_in.dest;
		end else if (out_ready) begin
			out_valid <= 1'b0;
		end
	end

endmodule

// ==== rtl/misc_alu.sv ====
`timescale 1ns/1ps

`include "misc_alu_consts.svh"

module misc_alu
	import misc_alu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input misc_req_t req,
	output logic out_valid,
	input logic out_ready,
	output misc_resp_t resp
);

	logic prep_valid;
	logic prep_ready;
	prep_t prep_stage;
	logic finish_valid;
	logic finish_ready;
	finish_t finish_stage;

	misc_alu_prep u_prep (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.req(req),
		.out_valid(prep_valid),
		.out_ready(prep_ready),
		.stage(prep_stage)
	);

	misc_alu_finish u_finish (
		.clk(clk),
		.reset(reset),
		.in_valid(prep_valid),
		.in_ready(prep_ready),
		.stage_in(prep_stage),
		.out_valid(finish_valid),
		.out_ready(finish_ready),
		.stage_out(finish_stage)
	);

	misc_alu_select u_select (
		.clk(clk),
		.reset(reset),
		.in_valid(finish_valid),
		.in_ready(finish_ready),
		.stage_in(finish_stage),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.resp(resp)
	);

endmodule

// ==== verif/misc_alu_tb.sv ====
`timescale 1ns/1ps

`include "misc_alu_consts.svh"

module misc_alu_tb
	import misc_alu_pkg::*;
();

	typedef struct packed {
		logic [1:0] group;
		misc_req_t req;
		acc_t expected;
	} entry_t;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	misc_req_t req;
	logic out_valid;
	logic out_ready;
	misc_resp_t resp;

	entry_t entries[0:63];
	int num_entries;
	string group_name[4];
	logic [31:0] lfsr_state;
	int checks;
	int errors;
	int group_checks;
	int group_errors;

	misc_alu UUT (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.req(req),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.resp(resp)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// taps 32, 22, 2 and 1.
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic add_entry(input logic [1:0] grp, input misc_op_t op, input word_t a,
			input word_t b, input word_t c, input acc_t acc, input shift_t shift,
			input logic sat_dis, input acc_t expected);
		entry_t e;
		e.group = grp;
		e.req.op = op;
		e.req.arg_a = a;
		e.req.arg_b = b;
		e.req.arg_c = c;
		e.req.accumulator = acc;
		e.req.shift = shift;
		e.req.saturate_disable = sat_dis;
		e.req.dest = num_entries[3:0]; // tags wrap every 16 entries.
		e.expected = expected;
		entries[num_entries] = e;
		num_entries++;
	endtask

	task automatic build_table();
		add_entry(0, `MISC_OP_LSH, 16'h1234, 16'h0, 16'h0, 32'h0, 4'd0, 1'b0, 32'h0000_1234);
		add_entry(0, `MISC_OP_LSH, 16'h1234, 16'h0, 16'h0, 32'h0, 4'd4, 1'b0, 32'h0000_2340);
		add_entry(0, `MISC_OP_LSH, 16'h0001, 16'h0, 16'h0, 32'h0, 4'd15, 1'b0, 32'hffff_8000);
		add_entry(0, `MISC_OP_LSH, 16'h00ff, 16'h0, 16'h0, 32'h0, 4'd9, 1'b0, 32'hffff_fe00);
		add_entry(0, `MISC_OP_RSH, 16'h8000, 16'h0, 16'h0, 32'h0, 4'd15, 1'b0, 32'h0000_0001);
		add_entry(0, `MISC_OP_RSH, 16'hfff0, 16'h0, 16'h0, 32'h0, 4'd4, 1'b0, 32'h0000_0fff);
		add_entry(0, `MISC_OP_RSH, 16'hfff0, 16'h0, 16'h0, 32'h0, 4'd0, 1'b0, 32'hffff_fff0);
		add_entry(0, `MISC_OP_RSH, 16'h8000, 16'h0, 16'h0, 32'h0, 4'd1, 1'b0, 32'h0000_4000);
		add_entry(1, `MISC_OP_ABS, 16'hfffb, 16'h0, 16'h0, 32'h0, 4'd0, 1'b0, 32'h0000_0005);
		add_entry(1, `MISC_OP_ABS, 16'h8000, 16'h0, 16'h0, 32'h0, 4'd0, 1'b0, 32'hffff_8000);
		add_entry(1, `MISC_OP_ABS, 16'h0064, 16'h0, 16'h0, 32'h0, 4'd0, 1'b0, 32'h0000_0064);
		add_entry(1, `MISC_OP_MIN, 16'hfffd, 16'h7, 16'h0, 32'h0, 4'd0, 1'b0, 32'hffff_fffd);
		add_entry(1, `MISC_OP_MAX, 16'hfffd, 16'h7, 16'h0, 32'h0, 4'd0, 1'b0, 32'h0000_0007);
		add_entry(1, `MISC_OP_MIN, 16'h7fff, 16'h8000, 16'h0, 32'h0, 4'd0, 1'b0, 32'hffff_8000);
		add_entry(1, `MISC_OP_MAX, 16'h7fff, 16'h8000, 16'h0, 32'h0, 4'd0, 1'b0, 32'h0000_7fff);
		add_entry(2, `MISC_OP_CLAMP, 16'hffce, 16'hfff6, 16'h14, 32'h0, 4'd0, 1'b0, 32'hffff_fff6);
		add_entry(2, `MISC_OP_CLAMP, 16'h0005, 16'hfff6, 16'h14, 32'h0, 4'd0, 1'b0, 32'h0000_0005);
		add_entry(2, `MISC_OP_CLAMP, 16'h012c, 16'hfff6, 16'h14, 32'h0, 4'd0, 1'b0, 32'h0000_0014);
		add_entry(2, `MISC_OP_CLAMP, 16'hffce, 16'h14, 16'hfff6, 32'h0, 4'd0, 1'b0, 32'hffff_fff6);
		add_entry(2, `MISC_OP_CLAMP, 16'h0005, 16'h14, 16'hfff6, 32'h0, 4'd0, 1'b0, 32'h0000_0005);
		add_entry(2, `MISC_OP_CLAMP, 16'h012c, 16'h14, 16'hfff6, 32'h0, 4'd0, 1'b0, 32'h0000_0014);
		add_entry(3, `MISC_OP_MOV_ACC, 16'h0, 16'h0, 16'h0, 32'h0000_1000, 4'd4, 1'b0, 32'h0000_0100);
		add_entry(3, `MISC_OP_MOV_ACC, 16'h0, 16'h0, 16'h0, 32'h8000_0000, 4'd15, 1'b1, 32'hffff_0000);
		add_entry(3, `MISC_OP_MOV_ACC, 16'h0, 16'h0, 16'h0, 32'h8000_0000, 4'd15, 1'b0, 32'hffff_8000);
		add_entry(3, `MISC_OP_MOV_ACC, 16'h0, 16'h0, 16'h0, 32'h1234_5678, 4'd0, 1'b0, 32'h0000_7fff);
		add_entry(3, `MISC_OP_MOV_ACC, 16'h0, 16'h0, 16'h0, 32'h1234_5678, 4'd0, 1'b1, 32'h1234_5678);
		add_entry(3, `MISC_OP_MOV_UACC, 16'h0, 16'h0, 16'h0, 32'h8001_1234, 4'd0, 1'b0, 32'hffff_8001);
		add_entry(3, `MISC_OP_MOV_LACC, 16'h0, 16'h0, 16'h0, 32'h8001_1234, 4'd0, 1'b0, 32'h0000_1234);
		add_entry(3, `MISC_OP_MOV_LACC, 16'h0, 16'h0, 16'h0, 32'h0000_c000, 4'd0, 1'b0, 32'hffff_c000);
		add_entry(3, 4'd12, 16'h1234, 16'h0, 16'h0, 32'h1234_5678, 4'd0, 1'b1, 32'h0000_0000);
	endtask

	task automatic check_idle(input string when);
		if (out_valid !== 1'b0) begin
			$display("Fail at %0t ns: out_valid is %b %s, expected 0", $time, out_valid, when);
			errors++;
		end
	endtask

	task automatic check_resp(input int idx);
		checks++;
		group_checks++;
		if (resp.result !== entries[idx].expected) begin
			$display("Fail at %0t ns: resp.result is %h, expected %h", $time, resp.result,
				entries[idx].expected);
			errors++;
			group_errors++;
		end
		if (resp.dest !== entries[idx].req.dest) begin
			$display("Fail at %0t ns: resp.dest is %h, expected %h", $time, resp.dest,
				entries[idx].req.dest);
			errors++;
			group_errors++;
		end
		if (idx == num_entries - 1 || entries[idx + 1].group != entries[idx].group) begin
			$display("%s finished: %0d checked, %0d errors", group_name[entries[idx].group],
				group_checks, group_errors);
			group_checks = 0;
			group_errors = 0;
		end
	endtask

	task automatic run_table(input logic use_lfsr);
		int sent;
		int got;
		int cycle;
		int first_cycle;
		logic ready_expected;
		sent = 0;
		got = 0;
		cycle = 0;
		first_cycle = 0;
		while (got < num_entries) begin
			@(negedge clk);
			cycle++;
			in_valid = sent < num_entries;
			req = (sent < num_entries) ? entries[sent].req : '0;
			if (use_lfsr) begin
				lfsr_state = lfsr_step(lfsr_state);
				out_ready = lfsr_state[0];
			end else begin
				out_ready = 1'b1;
			end
			#1; // let the ready chain settle before sampling.
			ready_expected = (sent - got < 3) || out_ready; // only a full pipeline can stall.
			if (in_ready !== ready_expected) begin
				$display("Fail at %0t ns: in_ready is %b, expected %b", $time, in_ready,
					ready_expected);
				errors++;
			end
			if (in_valid && in_ready) begin
				if (sent == 0) begin
					first_cycle = cycle;
				end
				sent++;
			end
			if (out_valid && out_ready) begin
				if (!use_lfsr && got == 0 && cycle - first_cycle != 3) begin
					$display("Fail at %0t ns: first result latency is %0d, expected 3", $time,
						cycle - first_cycle);
					errors++;
				end
				check_resp(got);
				got++;
			end
		end
		@(negedge clk);
		in_valid = 1'b0;
		req = '0;
		out_ready = 1'b1;
		repeat (4) begin
			@(negedge clk);
			check_idle("after the last expected result");
		end
	endtask

	initial begin
		#1;
		repeat (40 * num_entries + 100) @(posedge clk);
		$display("Timeout: the DUT did not return all results in time.");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		group_name[0] = "shifts";
		group_name[1] = "abs, min and max";
		group_name[2] = "clamp";
		group_name[3] = "accumulator moves";
		num_entries = 0;
		checks = 0;
		errors = 0;
		group_checks = 0;
		group_errors = 0;
		lfsr_state = 32'h69f0_76bb;
		reset = 1'b1;
		in_valid = 1'b0;
		req = '0;
		out_ready = 1'b0;
		build_table();
		repeat (4) begin
			@(negedge clk);
			check_idle("during reset");
		end
		reset = 1'b0;
		@(negedge clk);
		check_idle("right after reset");
		run_table(1'b0); // full throughput, also measures latency.
		run_table(1'b1);
		$display("checked %0d results, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== misc_alu.f ====
+incdir+rtl
rtl/misc_alu_pkg.sv
rtl/misc_alu_prep.sv
rtl/misc_alu_finish.sv
rtl/misc_alu_select.sv
rtl/misc_alu.sv
verif/misc_alu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -Wno-fatal -f misc_alu.f \
	--top-module misc_alu_tb -o misc_alu_sim > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
	cat "$BUILD_LOG"
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/misc_alu_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$SIM_LOG"; then
	exit 1
fi
if ! grep -q "Simulation passed" "$SIM_LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
